//--- logic/cpu_pkg.sv
package cpu_pkg;

   // one data byte on the bus or in a register
   typedef logic [7:0] byte_t;

   // full 16-bit bus address
   typedef logic [15:0] addr_t;

   // cycle index inside one instruction
   typedef logic [2:0] cyc_t;

   // architectural flags, ordered N, Z, C
   typedef logic [2:0] flags_t;

   // first opcode fetch after reset
   localparam addr_t RESET_VECTOR_DEFAULT = 16'h0200;

endpackage

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

   // first eight values follow the aaa field of the cc=01 group
   // STA sits at aaa=4 and touches no flags, so it maps to NONE
   typedef enum logic [3:0] {
      ALU_ORA  = 4'd0,
      ALU_AND  = 4'd1,
      ALU_EOR  = 4'd2,
      ALU_ADC  = 4'd3,
      ALU_NONE = 4'd4,
      ALU_FWD  = 4'd5,
      ALU_CMP  = 4'd6,
      ALU_SBC  = 4'd7,
      ALU_INC  = 4'd8,
      ALU_DEC  = 4'd9,
      ALU_CLC  = 4'd10,
      ALU_SEC  = 4'd11
   } alu_op_e;

   typedef enum logic [1:0] {
      OP1_A,
      OP1_X,
      OP1_Y
   } op1_src_e;

   // without a bus operand the second lane carries op1
   typedef enum logic [1:0] {
      OP2_DATA_BUS,
      OP2_NONE
   } op2_src_e;

   // OP1 loads the register picked by op1_src for transfers
   typedef enum logic [1:0] {
      LOAD_NONE,
      LOAD_ALU,
      LOAD_OP1
   } reg_load_e;

   typedef enum logic {
      ADDR_PC,
      ADDR_ZPG
   } addr_src_e;

   typedef enum logic {
      CYC_INCR,
      CYC_RESET
   } cyc_ctrl_e;

   typedef enum logic [1:0] {
      PC_HOLD,
      PC_INCR,
      PC_JUMP
   } pc_ctrl_e;

endpackage

//--- logic/control_rom.sv
`timescale 1ns/1ps

module control_rom (
   input  cpu_pkg::byte_t       opcode,
   input  cpu_pkg::cyc_t        cyc,
   output ctrl_pkg::alu_op_e    alu_op,
   output ctrl_pkg::op1_src_e   op1_src,
   output ctrl_pkg::op2_src_e   op2_src,
   output ctrl_pkg::reg_load_e  a_load,
   output ctrl_pkg::reg_load_e  x_load,
   output ctrl_pkg::reg_load_e  y_load,
   output ctrl_pkg::addr_src_e  addr_src,
   output ctrl_pkg::pc_ctrl_e   pc_ctrl,
   output ctrl_pkg::cyc_ctrl_e  cyc_ctrl,
   output logic                 we
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;

   assign aaa = opcode[7:5];
   assign bbb = opcode[4:2];
   assign cc  = opcode[1:0];

   always_comb begin
      // defaults describe a 2-cycle NOP
      alu_op   = ctrl_pkg::ALU_NONE;
      op1_src  = ctrl_pkg::OP1_A;
      op2_src  = ctrl_pkg::OP2_NONE;
      a_load   = ctrl_pkg::LOAD_NONE;
      x_load   = ctrl_pkg::LOAD_NONE;
      y_load   = ctrl_pkg::LOAD_NONE;
      addr_src = ctrl_pkg::ADDR_PC;
      pc_ctrl  = ctrl_pkg::PC_HOLD;
      cyc_ctrl = ctrl_pkg::CYC_RESET;
      we       = 1'b0;

      if (cyc == 3'd0) begin
         // opcode fetch
         pc_ctrl  = ctrl_pkg::PC_INCR;
         cyc_ctrl = ctrl_pkg::CYC_INCR;
      end else begin
         case (cc)
            2'b01: begin
               if (bbb == 3'b010 && aaa != 3'd4) begin
                  // immediate operand straight off the bus
                  op2_src = ctrl_pkg::OP2_DATA_BUS;
                  pc_ctrl = ctrl_pkg::PC_INCR;
                  alu_op  = ctrl_pkg::alu_op_e'({1'b0, aaa});
                  if (aaa != 3'd6) begin
                     a_load = ctrl_pkg::LOAD_ALU;
                  end
               end else if (bbb == 3'b001) begin
                  if (cyc == 3'd1) begin
                     // sequencer latches the zero-page address
                     pc_ctrl  = ctrl_pkg::PC_INCR;
                     cyc_ctrl = ctrl_pkg::CYC_INCR;
                  end else begin
                     addr_src = ctrl_pkg::ADDR_ZPG;
                     op2_src  = ctrl_pkg::OP2_DATA_BUS;
                     alu_op   = ctrl_pkg::alu_op_e'({1'b0, aaa});
                     if (aaa == 3'd4) begin
                        we = 1'b1;
                     end else if (aaa != 3'd6) begin
                        a_load = ctrl_pkg::LOAD_ALU;
                     end
                  end
               end
            end

            2'b00: begin
               case ({aaa, bbb})
                  // JMP abs
                  6'b010_011: begin
                     if (cyc == 3'd1) begin
                        pc_ctrl  = ctrl_pkg::PC_INCR;
                        cyc_ctrl = ctrl_pkg::CYC_INCR;
                     end else begin
                        pc_ctrl = ctrl_pkg::PC_JUMP;
                     end
                  end
                  // LDY #
                  6'b101_000: begin
                     op2_src = ctrl_pkg::OP2_DATA_BUS;
                     pc_ctrl = ctrl_pkg::PC_INCR;
                     alu_op  = ctrl_pkg::ALU_FWD;
                     y_load  = ctrl_pkg::LOAD_ALU;
                  end
                  // TAY
                  6'b101_010: begin
                     alu_op = ctrl_pkg::ALU_FWD;
                     y_load = ctrl_pkg::LOAD_OP1;
                  end
                  // TYA
                  6'b100_110: begin
                     op1_src = ctrl_pkg::OP1_Y;
                     alu_op  = ctrl_pkg::ALU_FWD;
                     a_load  = ctrl_pkg::LOAD_OP1;
                  end
                  // INY, DEY
                  6'b110_010, 6'b100_010: begin
                     op1_src = ctrl_pkg::OP1_Y;
                     alu_op  = aaa[1] ? ctrl_pkg::ALU_INC : ctrl_pkg::ALU_DEC;
                     y_load  = ctrl_pkg::LOAD_ALU;
                  end
                  // INX
                  6'b111_010: begin
                     op1_src = ctrl_pkg::OP1_X;
                     alu_op  = ctrl_pkg::ALU_INC;
                     x_load  = ctrl_pkg::LOAD_ALU;
                  end
                  6'b000_110: alu_op = ctrl_pkg::ALU_CLC;
                  6'b001_110: alu_op = ctrl_pkg::ALU_SEC;
                  default: begin
                  end
               endcase
            end

            2'b10: begin
               case ({aaa, bbb})
                  // LDX #
                  6'b101_000: begin
                     op2_src = ctrl_pkg::OP2_DATA_BUS;
                     pc_ctrl = ctrl_pkg::PC_INCR;
                     alu_op  = ctrl_pkg::ALU_FWD;
                     x_load  = ctrl_pkg::LOAD_ALU;
                  end
                  // TAX
                  6'b101_010: begin
                     alu_op = ctrl_pkg::ALU_FWD;
                     x_load = ctrl_pkg::LOAD_OP1;
                  end
                  // TXA
                  6'b100_010: begin
                     op1_src = ctrl_pkg::OP1_X;
                     alu_op  = ctrl_pkg::ALU_FWD;
                     a_load  = ctrl_pkg::LOAD_OP1;
                  end
                  // DEX
                  6'b110_010: begin
                     op1_src = ctrl_pkg::OP1_X;
                     alu_op  = ctrl_pkg::ALU_DEC;
                     x_load  = ctrl_pkg::LOAD_ALU;
                  end
                  default: begin
                  end
               endcase
            end

            default: begin
            end
         endcase
      end
   end

endmodule

//--- logic/sequencer.sv
`timescale 1ns/1ps

module sequencer #(
   parameter cpu_pkg::addr_t RESET_VECTOR = cpu_pkg::RESET_VECTOR_DEFAULT
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  cpu_pkg::byte_t       rdata,
   input  ctrl_pkg::pc_ctrl_e   pc_ctrl,
   input  ctrl_pkg::cyc_ctrl_e  cyc_ctrl,
   input  ctrl_pkg::addr_src_e  addr_src,
   output cpu_pkg::byte_t       opcode,
   output cpu_pkg::byte_t       operand,
   output cpu_pkg::cyc_t        cyc,
   output cpu_pkg::addr_t       addr,
   output logic                 sync
);

   cpu_pkg::addr_t pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cyc <= '0;
         pc  <= RESET_VECTOR;
      end else begin
         cyc <= (cyc_ctrl == ctrl_pkg::CYC_RESET) ? 3'd0 : cyc + 3'd1;
         case (pc_ctrl)
            ctrl_pkg::PC_INCR: pc <= pc + 16'd1;
            // high byte is on the bus now, low byte sits in the latch
            ctrl_pkg::PC_JUMP: pc <= {rdata, operand};
            default:           pc <= pc;
         endcase
      end
   end

   // instruction register and operand latch
   always_ff @(posedge clk) begin
      if (cyc == 3'd0) begin
         opcode <= rdata;
      end
      if (cyc == 3'd1) begin
         operand <= rdata;
      end
   end

   assign addr = (addr_src == ctrl_pkg::ADDR_ZPG) ? {8'h00, operand} : pc;
   assign sync = (cyc == 3'd0);

   // longest kept instruction is 3 cycles
   a_cyc_range: assert property (@(posedge clk) disable iff (!rst_n) cyc <= 3'd2);

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
   input  logic               clk,
   input  logic               rst_n,
   input  ctrl_pkg::alu_op_e  alu_op,
   input  cpu_pkg::byte_t     op1,
   input  cpu_pkg::byte_t     op2,
   output cpu_pkg::byte_t     alu_out,
   output cpu_pkg::flags_t    flags
);

   logic       n_q;
   logic       z_q;
   logic       c_q;
   logic [8:0] sum;

   always_comb begin
      sum     = 9'd0;
      alu_out = op2;
      case (alu_op)
         ctrl_pkg::ALU_ORA: alu_out = op1 | op2;
         ctrl_pkg::ALU_AND: alu_out = op1 & op2;
         ctrl_pkg::ALU_EOR: alu_out = op1 ^ op2;
         ctrl_pkg::ALU_ADC: begin
            sum     = {1'b0, op1} + {1'b0, op2} + {8'd0, c_q};
            alu_out = sum[7:0];
         end
         // borrow is the inverted carry
         ctrl_pkg::ALU_SBC: begin
            sum     = {1'b0, op1} + {1'b0, ~op2} + {8'd0, c_q};
            alu_out = sum[7:0];
         end
         ctrl_pkg::ALU_CMP: begin
            sum     = {1'b0, op1} + {1'b0, ~op2} + 9'd1;
            alu_out = sum[7:0];
         end
         ctrl_pkg::ALU_INC: alu_out = op1 + 8'd1;
         ctrl_pkg::ALU_DEC: alu_out = op1 - 8'd1;
         default:           alu_out = op2;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         n_q <= 1'b0;
         z_q <= 1'b0;
         c_q <= 1'b0;
      end else begin
         case (alu_op)
            ctrl_pkg::ALU_ORA, ctrl_pkg::ALU_AND, ctrl_pkg::ALU_EOR,
            ctrl_pkg::ALU_FWD, ctrl_pkg::ALU_INC, ctrl_pkg::ALU_DEC: begin
               n_q <= alu_out[7];
               z_q <= (alu_out == 8'h00);
            end
            ctrl_pkg::ALU_ADC, ctrl_pkg::ALU_SBC, ctrl_pkg::ALU_CMP: begin
               n_q <= alu_out[7];
               z_q <= (alu_out == 8'h00);
               c_q <= sum[8];
            end
            ctrl_pkg::ALU_CLC: c_q <= 1'b0;
            ctrl_pkg::ALU_SEC: c_q <= 1'b1;
            default: begin
            end
         endcase
      end
   end

   assign flags = {n_q, z_q, c_q};

   // defined codes run contiguously up to SEC
   a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
      alu_op <= ctrl_pkg::ALU_SEC);

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic                 clk,
   input  logic                 rst_n,
   input  cpu_pkg::byte_t       alu_out,
   input  ctrl_pkg::reg_load_e  a_load,
   input  ctrl_pkg::reg_load_e  x_load,
   input  ctrl_pkg::reg_load_e  y_load,
   input  ctrl_pkg::op1_src_e   op1_src,
   output cpu_pkg::byte_t       op1,
   output cpu_pkg::byte_t       wdata
);

   cpu_pkg::byte_t a_q;
   cpu_pkg::byte_t x_q;
   cpu_pkg::byte_t y_q;

   // next value of one register for a given load select
   function automatic cpu_pkg::byte_t next_value(ctrl_pkg::reg_load_e sel,
                                                 cpu_pkg::byte_t cur);
      case (sel)
         ctrl_pkg::LOAD_ALU: return alu_out;
         ctrl_pkg::LOAD_OP1: return op1;
         default:            return cur;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         a_q <= '0;
         x_q <= '0;
         y_q <= '0;
      end else begin
         a_q <= next_value(a_load, a_q);
         x_q <= next_value(x_load, x_q);
         y_q <= next_value(y_load, y_q);
      end
   end

   always_comb begin
      case (op1_src)
         ctrl_pkg::OP1_X: op1 = x_q;
         ctrl_pkg::OP1_Y: op1 = y_q;
         default:         op1 = a_q;
      endcase
   end

   // STA is the only store
   assign wdata = a_q;

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
   parameter cpu_pkg::addr_t RESET_VECTOR = cpu_pkg::RESET_VECTOR_DEFAULT
) (
   input  logic             clk,
   input  logic             rst_n,
   input  cpu_pkg::byte_t   rdata,
   output cpu_pkg::addr_t   addr,
   output cpu_pkg::byte_t   wdata,
   output logic             we,
   output logic             sync,
   output cpu_pkg::flags_t  flags
);

   ctrl_pkg::alu_op_e    alu_op;
   ctrl_pkg::op1_src_e   op1_src;
   ctrl_pkg::op2_src_e   op2_src;
   ctrl_pkg::reg_load_e  a_load;
   ctrl_pkg::reg_load_e  x_load;
   ctrl_pkg::reg_load_e  y_load;
   ctrl_pkg::addr_src_e  addr_src;
   ctrl_pkg::pc_ctrl_e   pc_ctrl;
   ctrl_pkg::cyc_ctrl_e  cyc_ctrl;
   cpu_pkg::byte_t       opcode;
   cpu_pkg::byte_t       operand;
   cpu_pkg::cyc_t        cyc;
   cpu_pkg::byte_t       op1;
   cpu_pkg::byte_t       op2;
   cpu_pkg::byte_t       alu_out;

   control_rom u_rom (
      .opcode   (opcode),
      .cyc      (cyc),
      .alu_op   (alu_op),
      .op1_src  (op1_src),
      .op2_src  (op2_src),
      .a_load   (a_load),
      .x_load   (x_load),
      .y_load   (y_load),
      .addr_src (addr_src),
      .pc_ctrl  (pc_ctrl),
      .cyc_ctrl (cyc_ctrl),
      .we       (we)
   );

   sequencer #(.RESET_VECTOR(RESET_VECTOR)) u_seq (
      .clk      (clk),
      .rst_n    (rst_n),
      .rdata    (rdata),
      .pc_ctrl  (pc_ctrl),
      .cyc_ctrl (cyc_ctrl),
      .addr_src (addr_src),
      .opcode   (opcode),
      .operand  (operand),
      .cyc      (cyc),
      .addr     (addr),
      .sync     (sync)
   );

   // transfers and INC/DEC see the register on both lanes
   assign op2 = (op2_src == ctrl_pkg::OP2_DATA_BUS) ? rdata : op1;

   alu u_alu (
      .clk     (clk),
      .rst_n   (rst_n),
      .alu_op  (alu_op),
      .op1     (op1),
      .op2     (op2),
      .alu_out (alu_out),
      .flags   (flags)
   );

   register_file u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .alu_out (alu_out),
      .a_load  (a_load),
      .x_load  (x_load),
      .y_load  (y_load),
      .op1_src (op1_src),
      .op1     (op1),
      .wdata   (wdata)
   );

endmodule

//--- tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

   localparam cpu_pkg::addr_t START_ADDR  = 16'h0200;
   localparam cpu_pkg::addr_t BLOCK2_ADDR = 16'h0300;
   localparam cpu_pkg::addr_t HALT_ADDR   = 16'h0308;
   localparam int TIMEOUT_CYCLES = 2000;

   logic            clk = 1'b0;
   logic            rst_n;
   cpu_pkg::byte_t  rdata;
   cpu_pkg::addr_t  addr;
   cpu_pkg::byte_t  wdata;
   logic            we;
   logic            sync;
   cpu_pkg::flags_t flags;

   cpu_pkg::byte_t mem [0:65535];
   cpu_pkg::byte_t ref_mem [0:65535];

   // architectural state of the reference model
   cpu_pkg::addr_t m_pc = START_ADDR;
   cpu_pkg::byte_t m_a = 8'h00;
   cpu_pkg::byte_t m_x = 8'h00;
   cpu_pkg::byte_t m_y = 8'h00;
   logic           m_n = 1'b0;
   logic           m_z = 1'b0;
   logic           m_c = 1'b0;

   // expectations for the instruction in flight
   int             exp_cycles = 0;
   logic           exp_write = 1'b0;
   cpu_pkg::addr_t exp_waddr = 16'h0000;
   cpu_pkg::byte_t exp_wdata = 8'h00;
   cpu_pkg::addr_t cur_pc = 16'h0000;

   int   errors = 0;
   int   main_errors = 0;
   int   checks = 0;
   int   cyc_count = 0;
   logic started = 1'b0;
   logic wrote = 1'b0;
   logic done = 1'b0;

   cpu_pkg::addr_t bp;
   cpu_pkg::addr_t sect_addr [$];
   string          sect_name [$];

   always #5 clk = ~clk;

   cpu_top #(.RESET_VECTOR(START_ADDR)) u_cpu_top (
      .clk   (clk),
      .rst_n (rst_n),
      .rdata (rdata),
      .addr  (addr),
      .wdata (wdata),
      .we    (we),
      .sync  (sync),
      .flags (flags)
   );

   // memory answers in the same cycle and stores on the edge
   assign rdata = mem[addr];

   always @(posedge clk) begin
      if (we === 1'b1) begin
         mem[addr] <= wdata;
      end
   end

   function automatic void set_nz(cpu_pkg::byte_t v);
      m_n = v[7];
      m_z = (v == 8'h00);
   endfunction

   // cc=01 group operation on A selected by aaa
   function automatic void acc_op(logic [2:0] aaa, cpu_pkg::byte_t v);
      int   s;
      logic borrow;
      borrow = ~m_c;
      case (aaa)
         3'd0: m_a = m_a | v;
         3'd1: m_a = m_a & v;
         3'd2: m_a = m_a ^ v;
         3'd3: begin
            s   = int'(m_a) + int'(v) + (m_c ? 1 : 0);
            m_a = 8'(s);
            m_c = (s > 255);
         end
         3'd5: m_a = v;
         3'd6: m_c = (m_a >= v);
         3'd7: begin
            m_c = ({1'b0, m_a} >= ({1'b0, v} + {8'd0, borrow}));
            m_a = m_a - v - {7'd0, borrow};
         end
         default: begin
         end
      endcase
      set_nz((aaa == 3'd6) ? m_a - v : m_a);
   endfunction

   // executes one instruction at m_pc on the model
   function automatic void model_step();
      cpu_pkg::byte_t op;
      cpu_pkg::byte_t b1;
      cpu_pkg::byte_t b2;
      op = ref_mem[m_pc];
      b1 = ref_mem[m_pc + 16'd1];
      b2 = ref_mem[m_pc + 16'd2];
      cur_pc     = m_pc;
      exp_write  = 1'b0;
      exp_cycles = 2;
      m_pc = m_pc + 16'd1;
      case (op)
         8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9: begin
            acc_op(op[7:5], b1);
            m_pc = m_pc + 16'd1;
         end
         8'h05, 8'h25, 8'h45, 8'h65, 8'hA5, 8'hC5, 8'hE5: begin
            acc_op(op[7:5], ref_mem[{8'h00, b1}]);
            m_pc = m_pc + 16'd1;
            exp_cycles = 3;
         end
         8'h85: begin
            exp_write  = 1'b1;
            exp_waddr  = {8'h00, b1};
            exp_wdata  = m_a;
            ref_mem[{8'h00, b1}] = m_a;
            m_pc = m_pc + 16'd1;
            exp_cycles = 3;
         end
         8'hA2: begin
            m_x = b1;
            set_nz(m_x);
            m_pc = m_pc + 16'd1;
         end
         8'hA0: begin
            m_y = b1;
            set_nz(m_y);
            m_pc = m_pc + 16'd1;
         end
         8'hAA: begin
            m_x = m_a;
            set_nz(m_x);
         end
         8'h8A: begin
            m_a = m_x;
            set_nz(m_a);
         end
         8'hA8: begin
            m_y = m_a;
            set_nz(m_y);
         end
         8'h98: begin
            m_a = m_y;
            set_nz(m_a);
         end
         8'hE8: begin
            m_x = m_x + 8'd1;
            set_nz(m_x);
         end
         8'hCA: begin
            m_x = m_x - 8'd1;
            set_nz(m_x);
         end
         8'hC8: begin
            m_y = m_y + 8'd1;
            set_nz(m_y);
         end
         8'h88: begin
            m_y = m_y - 8'd1;
            set_nz(m_y);
         end
         8'h18: m_c = 1'b0;
         8'h38: m_c = 1'b1;
         8'h4C: begin
            m_pc = {b2, b1};
            exp_cycles = 3;
         end
         // NOP and anything outside the subset
         default: begin
         end
      endcase
   endfunction

   function automatic string test_name(cpu_pkg::addr_t pc);
      string name;
      name = "reset";
      foreach (sect_addr[i]) begin
         if (pc >= sect_addr[i]) begin
            name = sect_name[i];
         end
      end
      return name;
   endfunction

   function automatic cpu_pkg::byte_t rnd8();
      return 8'($urandom);
   endfunction

   function automatic logic [2:0] acc_aaa(int k);
      case (k)
         0: return 3'd0;
         1: return 3'd1;
         2: return 3'd2;
         3: return 3'd3;
         4: return 3'd7;
         default: return 3'd5;
      endcase
   endfunction

   task automatic put(cpu_pkg::byte_t b);
      mem[bp] = b;
      bp = bp + 16'd1;
   endtask

   task automatic put2(cpu_pkg::byte_t op, cpu_pkg::byte_t b);
      put(op);
      put(b);
   endtask

   task automatic mark(string name);
      sect_addr.push_back(bp);
      sect_name.push_back(name);
   endtask

   task automatic build_program();
      cpu_pkg::addr_t fa;
      cpu_pkg::byte_t v;
      cpu_pkg::byte_t w;
      cpu_pkg::byte_t zp;
      logic [2:0]     aaa;
      int             k;
      fa = 16'h0000;
      do begin
         mem[fa] = fa[15:8] ^ fa[7:0] ^ 8'h5a;
         fa = fa + 16'd1;
      end while (fa != 16'h0000);
      bp = START_ADDR;
      mark("acc_imm_zpg");
      for (k = 0; k < 6; k++) begin
         aaa = acc_aaa(k);
         zp  = 8'h10 + 8'(k);
         mem[{8'h00, zp}] = rnd8();
         put2(8'hA9, rnd8());
         put2({aaa, 5'b01001}, rnd8());
         put2(8'h85, 8'h80 + 8'(k));
         put2(8'hA9, rnd8());
         put2({aaa, 5'b00101}, zp);
         put2(8'h85, 8'h90 + 8'(k));
      end
      mark("cmp");
      for (k = 0; k < 4; k++) begin
         zp = 8'h20 + 8'(k);
         mem[{8'h00, zp}] = rnd8();
         put2(8'hA9, rnd8());
         put2(8'hC9, rnd8());
         put2(8'h85, 8'hA0 + 8'(k));
         put2(8'hC5, zp);
         put2(8'h85, 8'hA4 + 8'(k));
      end
      // equal operands give Z and C
      v = rnd8();
      put2(8'hA9, v);
      put2(8'hC9, v);
      put2(8'h85, 8'hA8);
      mark("index");
      put2(8'hA2, rnd8());
      put(8'h8A);
      put2(8'h85, 8'hB0);
      put2(8'hA0, rnd8());
      put(8'h98);
      put2(8'h85, 8'hB1);
      put2(8'hA9, rnd8());
      put(8'hAA);
      put(8'hE8);
      put(8'hA8);
      put(8'h88);
      put(8'h88);
      put(8'hCA);
      put(8'h8A);
      put2(8'h85, 8'hB2);
      put(8'h98);
      put2(8'h85, 8'hB3);
      // FF to 00 on X then 00 to FF and back on Y
      put2(8'hA2, 8'hFF);
      put(8'hE8);
      put(8'h8A);
      put2(8'h85, 8'hB4);
      put2(8'hA0, 8'h00);
      put(8'h88);
      put(8'hC8);
      put(8'h98);
      put2(8'h85, 8'hB5);
      mark("carry");
      v = rnd8();
      w = rnd8();
      put(8'h18);
      put2(8'hA9, v);
      put2(8'h69, w);
      put2(8'h85, 8'hB8);
      put(8'h38);
      put2(8'hA9, v);
      put2(8'h69, w);
      put2(8'h85, 8'hB9);
      mark("jmp");
      put(8'hEA);
      put(8'h4C);
      put2(BLOCK2_ADDR[7:0], BLOCK2_ADDR[15:8]);
      bp = BLOCK2_ADDR;
      put2(8'hA9, rnd8());
      put2(8'h85, 8'hF0);
      put(8'hEA);
      put(8'h4C);
      put2(HALT_ADDR[7:0], HALT_ADDR[15:8]);
      // parks the core at the halt address
      put(8'h4C);
      put2(HALT_ADDR[7:0], HALT_ADDR[15:8]);
   endtask

   // compares each sync and each bus write against the model
   always @(negedge clk) begin
      if (rst_n === 1'b1 && !done) begin
         cyc_count++;
         if (sync === 1'b1) begin
            if (started) begin
               checks += 3;
               assert (cyc_count == exp_cycles) else begin
                  errors++;
                  $display("ERROR %s: cycles of op at %h expected %0d actual %0d",
                           test_name(cur_pc), cur_pc, exp_cycles, cyc_count);
               end
               assert (wrote || !exp_write) else begin
                  errors++;
                  $display("%s: the STA at %h made no bus write", test_name(cur_pc), cur_pc);
               end
               assert (flags === {m_n, m_z, m_c}) else begin
                  errors++;
                  $display("ERROR %s: NZC after op at %h expected %b actual %b",
                           test_name(cur_pc), cur_pc, {m_n, m_z, m_c}, flags);
               end
            end
            checks++;
            assert (addr === m_pc) else begin
               errors++;
               $display("ERROR %s: fetch address expected %h actual %h",
                        test_name(m_pc), m_pc, addr);
            end
            started   = 1'b1;
            cyc_count = 0;
            wrote     = 1'b0;
            if (addr === HALT_ADDR) begin
               done = 1'b1;
            end else begin
               model_step();
            end
         end else if (we === 1'b1) begin
            checks++;
            wrote = 1'b1;
            assert (exp_write && cyc_count == 2) else begin
               errors++;
               $display("%s: unexpected bus write at %h in cycle %0d of op at %h",
                        test_name(cur_pc), addr, cyc_count, cur_pc);
            end
            if (exp_write) begin
               assert (addr === exp_waddr) else begin
                  errors++;
                  $display("ERROR %s: write address expected %h actual %h",
                           test_name(cur_pc), exp_waddr, addr);
               end
               assert (wdata === exp_wdata) else begin
                  errors++;
                  $display("ERROR %s: write data at %h expected %h actual %h",
                           test_name(cur_pc), exp_waddr, exp_wdata, wdata);
               end
            end
         end
      end
   end

   initial begin
      int i;
      int wait_cycles;
      rst_n = 1'b0;
      void'($urandom(32'hd7db_3f29));
      build_program();
      ref_mem = mem;
      for (i = 0; i < 4; i++) begin
         @(posedge clk);
         #1;
         assert (we === 1'b0) else begin
            main_errors++;
            $display("write strobe was high while reset was held");
         end
      end
      rst_n = 1'b1;
      wait_cycles = 0;
      while (!done && wait_cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (!done) begin
         main_errors++;
         $display("timeout: no fetch from %h within %0d cycles", HALT_ADDR, TIMEOUT_CYCLES);
      end
      $display("%0d checks, %0d errors", checks + 4, errors + main_errors);
      if (errors + main_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
logic/cpu_pkg.sv
logic/ctrl_pkg.sv
logic/control_rom.sv
logic/sequencer.sv
logic/alu.sv
logic/register_file.sv
logic/cpu_top.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vcpu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
